// ==== project.f ====
common/mul16_pkg.sv
mul8_array/mul8_array.sv
cla32/cla_group4.sv
cla32/cla32.sv
hw/operand_capture.sv
hw/subproduct_stage.sv
hw/product_reduce.sv
hw/mul16_top.sv
testbench/mul16_chk.sv
testbench/tb_mul16.sv

// ==== Makefile ====
# Verilator build and run for the mul16 testbench

TOP             ?= tb_mul16
SIM_DIR         ?= sim_build
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f project.f
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "*** TEST FAILED ***" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)

// ==== testbench/tb_mul16.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for mul16_top.
// Inputs change on the falling edge and
// outputs are sampled there too.
// Expected products are queued per strobe.
// Run length is bounded by a cycle limit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module tb_mul16;

  localparam int NUM_VEC  = 14;
  localparam int NUM_RAND = 200;
  localparam int PW       = mul16_pkg::PRODUCT_W;

  // Rows hold the idle gap before the pair, then a and b
  localparam logic [39:0] VEC_TAB [NUM_VEC] = '{
    {8'd0, 16'h0000, 16'h1234}, {8'd0, 16'hABCD, 16'h0000},
    {8'd2, 16'h0001, 16'hBEEF}, {8'd0, 16'hFFFF, 16'hFFFF},
    {8'd1, 16'h00FF, 16'hFF00}, {8'd3, 16'h8000, 16'h8000},
    {8'd0, 16'h01FF, 16'h01FF}, {8'd5, 16'h01FF, 16'hFFFF},
    {8'd0, 16'hFFFF, 16'h01FF}, {8'd2, 16'h80FF, 16'h7FFF},
    {8'd0, 16'h55FF, 16'hAAFF}, {8'd4, 16'hC3FF, 16'h3CFF},
    {8'd0, 16'hFEFF, 16'hFFFF}, {8'd1, 16'h1234, 16'h0001}
  };

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 in_stb;
  mul16_pkg::operands_t ops;
  logic [PW-1:0]        product;
  logic                 out_stb;

  logic [PW-1:0] exp_q [$];
  logic [PW-1:0] exp_val;
  logic [31:0]   lfsr_state = 32'h1420;
  int            errors = 0;
  int            other_errors = 0;
  int            in_count = 0;
  int            out_count = 0;

  mul16_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_stb  (in_stb),
    .ops     (ops),
    .product (product),
    .out_stb (out_stb)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_operand(output logic [15:0] w);
    int n;
    w = '0;
    for (n = 0; n < 16; n++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[14:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input logic [PW-1:0] got, input logic [PW-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One-cycle strobe with the pair; returns on the next falling edge
  task automatic drive_pair(input logic [15:0] a, input logic [15:0] b);
    ops.a  = a;
    ops.b  = b;
    in_stb = 1'b1;
    exp_q.push_back({16'h0000, a} * {16'h0000, b});
    in_count++;
    @(negedge clk);
    in_stb = 1'b0;
  endtask

  always @(negedge clk) begin
    if (rst_n && out_stb) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("Result strobe at %0t with no operation outstanding", $time);
        other_errors++;
      end else begin
        exp_val = exp_q.pop_front();
        check_value(product, exp_val, "product");
      end
    end
  end

  initial begin : main_seq
    logic [15:0] ra;
    logic [15:0] rb;
    int i;
    rst_n  = 1'b0;
    in_stb = 1'b0;
    ops    = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Idle pipeline right after reset
    check_value(32'(out_stb), 32'd0, "out_stb after reset");
    check_value(product, 32'd0, "product after reset");
    for (i = 0; i < NUM_VEC; i++) begin
      repeat (int'(VEC_TAB[i][39:32])) @(negedge clk);
      drive_pair(VEC_TAB[i][31:16], VEC_TAB[i][15:0]);
    end
    for (i = 0; i < NUM_RAND; i++) begin
      random_operand(ra);
      random_operand(rb);
      drive_pair(ra, rb);
    end
    wait (out_count == in_count);
    // Extra idle cycles catch stray strobes
    repeat (mul16_pkg::LATENCY + 2) @(negedge clk);
    if (exp_q.size() != 0 || out_count != in_count) begin
      $display("Run ended with %0d strobes in and %0d results out", in_count, out_count);
      other_errors++;
    end
    $display("Errors: %0d value mismatches, %0d other failures", errors, other_errors);
    if (errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    int gap_sum;
    int cycle_limit;
    int cycles;
    gap_sum = 0;
    cycles  = 0;
    for (int i = 0; i < NUM_VEC; i++) begin
      gap_sum += int'(VEC_TAB[i][39:32]);
    end
    cycle_limit = 2 * (NUM_VEC + gap_sum + NUM_RAND) + mul16_pkg::LATENCY + 20;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/mul16_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol assertions for mul16_top,
// attached by bind.
// Assumes in_stb is low during reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module mul16_chk (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            in_stb,
  input logic                            out_stb,
  input logic [mul16_pkg::PRODUCT_W-1:0] product
);

  // Result strobe mirrors the input strobe LATENCY cycles late
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    out_stb == $past(in_stb, mul16_pkg::LATENCY))
    else $error("out_stb does not follow in_stb by the pipeline latency");

  a_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({out_stb, product}))
    else $error("out_stb or product unknown");

  a_reset_quiet : assert property (@(posedge clk) !rst_n |-> !out_stb)
    else $error("out_stb high during reset");

endmodule

bind mul16_top mul16_chk u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .in_stb  (in_stb),
  .out_stb (out_stb),
  .product (product)
);

`default_nettype wire

// ==== hw/mul16_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipelined 16 x 16 unsigned multiplier.
// out_stb follows in_stb by three cycles
// (mul16_pkg::LATENCY), in input order.
// There is no back-pressure.
// The consumer must take every out_stb.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module mul16_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_stb,
  input  mul16_pkg::operands_t            ops,
  output logic [mul16_pkg::PRODUCT_W-1:0] product,
  output logic                            out_stb
);

  mul16_pkg::operands_t    cap_ops;
  logic                    cap_vld;
  mul16_pkg::subproducts_t sp;
  logic                    sp_vld;

  operand_capture u_capture (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_stb  (in_stb),
    .ops     (ops),
    .cap_ops (cap_ops),
    .cap_vld (cap_vld)
  );

  subproduct_stage u_subprod (
    .clk     (clk),
    .rst_n   (rst_n),
    .cap_ops (cap_ops),
    .cap_vld (cap_vld),
    .sp      (sp),
    .sp_vld  (sp_vld)
  );

  product_reduce u_reduce (
    .clk     (clk),
    .rst_n   (rst_n),
    .sp      (sp),
    .sp_vld  (sp_vld),
    .product (product),
    .out_stb (out_stb)
  );

endmodule

`default_nettype wire

// ==== hw/product_reduce.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Last pipeline stage.
// Aligns the cross products by one byte,
// adds them onto {hh, ll} and registers
// the product. out_stb is a one-cycle
// pulse; product holds until the next.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module product_reduce (
  input  logic                             clk,
  input  logic                             rst_n,
  input  mul16_pkg::subproducts_t          sp,
  input  logic                             sp_vld,
  output logic [mul16_pkg::PRODUCT_W-1:0]  product,
  output logic                             out_stb
);

  localparam int BW = mul16_pkg::BYTE_W;
  localparam int PW = mul16_pkg::PRODUCT_W;

  logic [PW-1:0] base_w;
  logic [PW-1:0] lh_w;
  logic [PW-1:0] hl_w;
  logic [PW-1:0] part_sum;
  logic [PW-1:0] full_sum;

  // hh and ll do not overlap, so they share one word
  assign base_w = {sp.hh, sp.ll};
  assign lh_w   = {{BW{1'b0}}, sp.lh, {BW{1'b0}}};
  assign hl_w   = {{BW{1'b0}}, sp.hl, {BW{1'b0}}};

  cla32 u_add_lh (.a(base_w),   .b(lh_w), .sum(part_sum));
  cla32 u_add_hl (.a(part_sum), .b(hl_w), .sum(full_sum));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_stb <= 1'b0;
      product <= '0;
    end else begin
      out_stb <= sp_vld;
      if (sp_vld) begin
        product <= full_sum;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/subproduct_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Second pipeline stage.
// Four exact byte multipliers, results
// registered on cap_vld, one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module subproduct_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mul16_pkg::operands_t    cap_ops,
  input  logic                    cap_vld,
  output mul16_pkg::subproducts_t sp,
  output logic                    sp_vld
);

  localparam int BW = mul16_pkg::BYTE_W;

  mul16_pkg::subproducts_t sp_comb;

  mul8_array u_ll (.a(cap_ops.a[BW-1:0]),    .b(cap_ops.b[BW-1:0]),    .p(sp_comb.ll));
  mul8_array u_lh (.a(cap_ops.a[BW-1:0]),    .b(cap_ops.b[2*BW-1:BW]), .p(sp_comb.lh));
  mul8_array u_hl (.a(cap_ops.a[2*BW-1:BW]), .b(cap_ops.b[BW-1:0]),    .p(sp_comb.hl));
  mul8_array u_hh (.a(cap_ops.a[2*BW-1:BW]), .b(cap_ops.b[2*BW-1:BW]), .p(sp_comb.hh));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sp_vld <= 1'b0;
    end else begin
      sp_vld <= cap_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (cap_vld) begin
      sp <= sp_comb;
    end
  end

endmodule

`default_nettype wire

// ==== hw/operand_capture.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Input register of the multiplier.
// Every cycle with in_stb high is taken;
// there is no back-pressure.
// cap_ops holds its value between strobes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module operand_capture (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_stb,
  input  mul16_pkg::operands_t ops,
  output mul16_pkg::operands_t cap_ops,
  output logic                 cap_vld
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_vld <= 1'b0;
    end else begin
      cap_vld <= in_stb;
    end
  end

  // Operands only move on an accepted strobe
  always_ff @(posedge clk) begin
    if (in_stb) begin
      cap_ops <= ops;
    end
  end

endmodule

`default_nettype wire

// ==== cla32/cla32.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit two-level carry-lookahead adder.
// Carry in is zero and the carry out is
// dropped.
// Callers must keep the true sum within
// 32 bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cla32 (
  input  logic [mul16_pkg::PRODUCT_W-1:0] a,
  input  logic [mul16_pkg::PRODUCT_W-1:0] b,
  output logic [mul16_pkg::PRODUCT_W-1:0] sum
);

  logic [mul16_pkg::PRODUCT_W-1:0] p;
  logic [mul16_pkg::PRODUCT_W-1:0] g;
  // Group terms; only those feeding a carry-in are formed
  logic [6:1] gp;
  logic [6:0] gg;
  logic [7:0] cc;

  assign p = a ^ b;
  assign g = a & b;

  genvar k;

  generate
    for (k = 0; k < 7; k++) begin : g_grp
      assign gg[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2]) |
                     (p[4*k+3] & p[4*k+2] & g[4*k+1]) |
                     (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
      if (k > 0) begin : g_prop
        assign gp[k] = &p[4*k+3:4*k];
      end
    end
  endgenerate

  // Second level over the group terms
  assign cc[0] = 1'b0;
  assign cc[1] = gg[0];
  assign cc[2] = gg[1] | (gp[1] & gg[0]);
  assign cc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0]);
  assign cc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1]) |
                 (gp[3] & gp[2] & gp[1] & gg[0]);
  assign cc[5] = gg[4] | (gp[4] & gg[3]) | (gp[4] & gp[3] & gg[2]) |
                 (gp[4] & gp[3] & gp[2] & gg[1]) |
                 (gp[4] & gp[3] & gp[2] & gp[1] & gg[0]);
  assign cc[6] = gg[5] | (gp[5] & gg[4]) | (gp[5] & gp[4] & gg[3]) |
                 (gp[5] & gp[4] & gp[3] & gg[2]) |
                 (gp[5] & gp[4] & gp[3] & gp[2] & gg[1]) |
                 (gp[5] & gp[4] & gp[3] & gp[2] & gp[1] & gg[0]);
  assign cc[7] = gg[6] | (gp[6] & gg[5]) | (gp[6] & gp[5] & gg[4]) |
                 (gp[6] & gp[5] & gp[4] & gg[3]) |
                 (gp[6] & gp[5] & gp[4] & gp[3] & gg[2]) |
                 (gp[6] & gp[5] & gp[4] & gp[3] & gp[2] & gg[1]) |
                 (gp[6] & gp[5] & gp[4] & gp[3] & gp[2] & gp[1] & gg[0]);

  generate
    for (k = 0; k < 8; k++) begin : g_sum
      cla_group4 u_grp (
        .p   (p[4*k+3:4*k]),
        .g   (g[4*k+3:4*k]),
        .cin (cc[k]),
        .sum (sum[4*k+3:4*k])
      );
    end
  endgenerate

endmodule

`default_nettype wire

// ==== cla32/cla_group4.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sum of one 4-bit lookahead group.
// Propagate and generate come from the
// parent adder; no carry out is formed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module cla_group4 (
  input  logic [3:0] p,
  input  logic [3:0] g,
  input  logic       cin,
  output logic [3:0] sum
);

  logic [3:0] c;

  assign c[0] = cin;
  assign c[1] = g[0] | (p[0] & cin);
  assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
  assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) |
                (p[2] & p[1] & p[0] & cin);

  assign sum = p ^ c;

endmodule

`default_nettype wire

// ==== mul8_array/mul8_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exact 8 x 8 unsigned multiplier.
// Carry-save array of adder rows with a
// ripple row at the end.
// Purely combinational.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module mul8_array (
  input  logic [mul16_pkg::BYTE_W-1:0]   a,
  input  logic [mul16_pkg::BYTE_W-1:0]   b,
  output logic [2*mul16_pkg::BYTE_W-1:0] p
);

  // pp[i][k] = a[k] & b[i] at weight i+k
  logic [7:0] pp [8];
  // Row sums; s[i][k] has weight i+k
  logic [7:0] s [8];
  // Row carries; c[i][k] has weight i+k+1
  logic [6:0] c [1:7];
  // Carries of the closing ripple row
  logic [7:0] rc;

  genvar i, k;

  generate
    for (i = 0; i < 8; i++) begin : g_pp
      assign pp[i] = a & {8{b[i]}};
    end
  endgenerate

  assign s[0] = pp[0];

  generate
    for (i = 1; i < 8; i++) begin : g_row
      for (k = 0; k < 7; k++) begin : g_cell
        if (i == 1) begin : g_ha
          assign s[i][k] = s[i-1][k+1] ^ pp[i][k];
          assign c[i][k] = s[i-1][k+1] & pp[i][k];
        end else begin : g_fa
          assign s[i][k] = s[i-1][k+1] ^ pp[i][k] ^ c[i-1][k];
          assign c[i][k] = (s[i-1][k+1] & pp[i][k]) |
                           (c[i-1][k] & (s[i-1][k+1] ^ pp[i][k]));
        end
      end
      // Top bit of each row passes straight down
      assign s[i][7] = pp[i][7];
      // One finished product bit per row
      assign p[i-1] = s[i-1][0];
    end
  endgenerate

  assign p[7] = s[7][0];

  // Merge the last sums and carries
  assign rc[0] = 1'b0;

  generate
    for (k = 0; k < 7; k++) begin : g_rip
      assign p[8+k]  = s[7][k+1] ^ c[7][k] ^ rc[k];
      assign rc[k+1] = (s[7][k+1] & c[7][k]) | (rc[k] & (s[7][k+1] ^ c[7][k]));
    end
  endgenerate

  assign p[15] = rc[7];

endmodule

`default_nettype wire

// ==== common/mul16_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and bundles for the
// pipelined 16 x 16 unsigned multiplier.
// The split is fixed at two bytes per
// operand; the widths are not free knobs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mul16_pkg;

  localparam int OPERAND_W = 16;
  localparam int BYTE_W    = 8;
  localparam int PRODUCT_W = 32;

  // In-strobe to out-strobe, in clock cycles
  localparam int LATENCY = 3;

  // Operand pair as presented on the input
  typedef struct packed {
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } operands_t;

  // Byte-pair products, named by the bytes of a and b
  typedef struct packed {
    logic [2*BYTE_W-1:0] ll;
    logic [2*BYTE_W-1:0] lh;
    logic [2*BYTE_W-1:0] hl;
    logic [2*BYTE_W-1:0] hh;
  } subproducts_t;

endpackage

`default_nettype wire
